/* common/cam_params.svh */
// Project-wide camera tile sizes and NoC header layout, included by the RTL and the testbench
`ifndef CAM_PARAMS_SVH
`define CAM_PARAMS_SVH

// Tile numbers in the mesh
`define CAM_TILE_ID     3  // Source, this camera tile
`define CAM_DEST_ID     0  // Compute tile receiving the lines

// Packetizer buffer, power of two
`define CAM_FIFO_DEPTH  8

// Header flit data fields
`define CAM_HDR_DEST_MSB   31
`define CAM_HDR_DEST_LSB   27
`define CAM_HDR_SRC_MSB    26
`define CAM_HDR_SRC_LSB    22
`define CAM_HDR_ZERO_MSB   21  // Reserved, always zero
`define CAM_HDR_ZERO_LSB   18
`define CAM_HDR_FRAME_MSB  17
`define CAM_HDR_FRAME_LSB  10
`define CAM_HDR_LINE_MSB   9
`define CAM_HDR_LINE_LSB   0

`endif

/* common/cam_pkg.sv */
// Shared types of the camera tile datapath and NoC link, referenced with cam_pkg:: scoping
package cam_pkg;

   // Camera side
   typedef logic [7:0]  cam_byte_t;   // One byte from the sensor port
   typedef logic [31:0] cam_word_t;   // Four bytes, first byte in bits 7..0
   typedef logic [9:0]  cam_line_t;   // Line within a frame
   typedef logic [7:0]  cam_frame_t;  // Frame counter, wraps

   // Lisnoc flit type field
   typedef logic [1:0]  flit_type_t;

   localparam flit_type_t FLIT_PAYLOAD = 2'b00;
   localparam flit_type_t FLIT_HEADER  = 2'b01;
   localparam flit_type_t FLIT_LAST    = 2'b10;

   // Type on top, then 32 data bits
   typedef logic [33:0] noc_flit_t;

   // Packetizer FSM
   typedef enum logic [1:0] {
      PKT_IDLE,    // Waiting for a buffered word
      PKT_HEADER,  // Header flit on the link
      PKT_BODY     // Payload flits until the last one
   } pkt_state_e;

endpackage

/* camera/cam_capture.sv */
// Camera port front end, oversamples pclk/href/vsync in the clk domain and emits event strobes
module cam_capture (
   input  logic               clk,
   input  logic               arst_n_i,
   input  logic               pclk_i,             // Sensor pixel clock, sampled as data
   input  logic               href_i,             // Line valid
   input  logic               vsync_i,            // Frame sync
   input  cam_pkg::cam_byte_t d_i,
   output logic               byte_stb_o,
   output cam_pkg::cam_byte_t byte_o,
   output logic               line_end_stb_o,
   output logic               frame_start_stb_o
);

   // Bit 0 first sync stage, bit 1 synchronized, bit 2 previous value
   logic [2:0] pclk_sync_q;
   logic [2:0] href_sync_q;
   logic [2:0] vsync_sync_q;

   // Data follows the control through two flops so it lines up with them
   cam_pkg::cam_byte_t d_meta_q;
   cam_pkg::cam_byte_t d_sync_q;

   logic pclk_rise;
   logic href_fall;
   logic vsync_rise;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pclk_sync_q  <= '0;
         href_sync_q  <= '0;
         vsync_sync_q <= '0;
      end else begin
         pclk_sync_q  <= {pclk_sync_q[1:0], pclk_i};
         href_sync_q  <= {href_sync_q[1:0], href_i};
         vsync_sync_q <= {vsync_sync_q[1:0], vsync_i};
      end
   end

   always_ff @(posedge clk) begin
      d_meta_q <= d_i;
      d_sync_q <= d_meta_q;
   end

   // Edges on the synchronized copies, two cycles after the input change
   assign pclk_rise  = pclk_sync_q[1] & ~pclk_sync_q[2];
   assign href_fall  = ~href_sync_q[1] & href_sync_q[2];
   assign vsync_rise = vsync_sync_q[1] & ~vsync_sync_q[2];

   // Registered strobes, third cycle after the input edge
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         byte_stb_o        <= 1'b0;
         line_end_stb_o    <= 1'b0;
         frame_start_stb_o <= 1'b0;
      end else begin
         byte_stb_o        <= pclk_rise & href_sync_q[1];  // Only inside a line
         line_end_stb_o    <= href_fall;
         frame_start_stb_o <= vsync_rise;
      end
   end

   always_ff @(posedge clk) begin
      if (pclk_rise) begin
         byte_o <= d_sync_q;  // Byte captured at the pixel clock edge
      end
   end

endmodule

/* camera/pixel_packer.sv */
// Packs camera bytes into tagged 32-bit words, one word strobe per word, last word of a line flagged
module pixel_packer (
   input  logic                clk,
   input  logic                arst_n_i,
   input  logic                byte_stb_i,
   input  cam_pkg::cam_byte_t  byte_i,
   input  logic                line_end_stb_i,
   input  logic                frame_start_stb_i,
   output logic                word_stb_o,
   output cam_pkg::cam_word_t  word_o,
   output logic                last_o,
   output cam_pkg::cam_line_t  line_o,
   output cam_pkg::cam_frame_t frame_o
);

   logic [1:0]          cnt_q;       // Bytes already in acc_q
   cam_pkg::cam_word_t  acc_q;       // Word being assembled, upper bytes zero
   cam_pkg::cam_word_t  hold_q;      // Full word held back for the last flag
   logic                hold_vld_q;  // Only set while cnt_q is zero
   cam_pkg::cam_line_t  line_q;
   cam_pkg::cam_frame_t frame_q;     // First frame after reset is 1

   logic                emit;
   logic                emit_last;
   logic                emit_tag;    // Load line/frame tag with this word
   cam_pkg::cam_word_t  emit_word;

   always_comb begin
      emit      = 1'b0;
      emit_last = 1'b0;
      emit_tag  = 1'b0;
      emit_word = hold_q;
      if (byte_stb_i && hold_vld_q) begin  // More data follows, held word is not last
         emit     = 1'b1;
         emit_tag = 1'b1;
      end else if (line_end_stb_i && hold_vld_q) begin  // Held word ends the line
         emit      = 1'b1;
         emit_tag  = 1'b1;
         emit_last = 1'b1;
      end else if (line_end_stb_i && cnt_q != 2'd0) begin
         emit      = 1'b1;
         emit_tag  = 1'b1;
         emit_last = 1'b1;
         emit_word = acc_q;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_q      <= 2'd0;
         hold_vld_q <= 1'b0;
         line_q     <= '0;
         frame_q    <= '0;
         word_stb_o <= 1'b0;
      end else begin
         word_stb_o <= emit;
         if (frame_start_stb_i) begin
            frame_q    <= frame_q + 1'b1;
            line_q     <= '0;
            cnt_q      <= 2'd0;  // Drop any stray partial word
            hold_vld_q <= 1'b0;
         end else if (byte_stb_i) begin
            cnt_q      <= cnt_q + 1'b1;        // Wraps after the fourth byte
            hold_vld_q <= (cnt_q == 2'd3);
         end else if (line_end_stb_i) begin
            cnt_q      <= 2'd0;
            hold_vld_q <= 1'b0;
            line_q     <= line_q + 1'b1;
         end
      end
   end

   // Datapath, little-endian byte lanes
   always_ff @(posedge clk) begin
      if (byte_stb_i) begin
         if (cnt_q == 2'd0) begin
            acc_q <= {24'h0, byte_i};   // Clears upper lanes for zero padding
         end else begin
            acc_q[cnt_q*8 +: 8] <= byte_i;
         end
         if (cnt_q == 2'd3) begin
            hold_q <= {byte_i, acc_q[23:0]};
         end
      end
      if (emit) begin
         word_o <= emit_word;
         last_o <= emit_last;
      end
      if (emit_tag) begin
         line_o  <= line_q;
         frame_o <= frame_q;
      end
   end

endmodule

/* verilog/noc_packetizer.sv */
// Buffers tagged words and sends one lisnoc packet per image line on the valid/ready link
`include "cam_params.svh"

module noc_packetizer (
   input  logic                clk,
   input  logic                arst_n_i,
   input  logic                word_stb_i,
   input  cam_pkg::cam_word_t  word_i,
   input  logic                last_i,
   input  cam_pkg::cam_line_t  line_i,
   input  cam_pkg::cam_frame_t frame_i,
   input  logic                noc_out_ready_i,
   output cam_pkg::noc_flit_t  noc_out_flit_o,
   output logic                noc_out_valid_o,
   output logic                overflow_o       // Sticky until reset
);

   localparam int AW = $clog2(`CAM_FIFO_DEPTH);

   // FIFO storage, one array per field
   cam_pkg::cam_word_t  mem_word  [`CAM_FIFO_DEPTH];
   cam_pkg::cam_line_t  mem_line  [`CAM_FIFO_DEPTH];
   cam_pkg::cam_frame_t mem_frame [`CAM_FIFO_DEPTH];
   logic                mem_last  [`CAM_FIFO_DEPTH];

   logic [AW-1:0] wr_ptr_q;  // Wraps at the depth
   logic [AW-1:0] rd_ptr_q;
   logic [AW:0]   count_q;

   logic empty;
   logic full;
   logic push;
   logic pop;

   cam_pkg::pkt_state_e state_q;
   cam_pkg::pkt_state_e state_d;
   cam_pkg::cam_word_t  hdr_data;

   assign empty = (count_q == '0);
   assign full  = (count_q == (AW+1)'(`CAM_FIFO_DEPTH));
   assign push  = word_stb_i & ~full;  // Full FIFO drops the word
   assign pop   = (state_q == cam_pkg::PKT_BODY) & ~empty & noc_out_ready_i;

   always_ff @(posedge clk) begin
      if (push) begin
         mem_word[wr_ptr_q]  <= word_i;
         mem_line[wr_ptr_q]  <= line_i;
         mem_frame[wr_ptr_q] <= frame_i;
         mem_last[wr_ptr_q]  <= last_i;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         overflow_o <= 1'b0;
         state_q    <= cam_pkg::PKT_IDLE;
      end else begin
         state_q <= state_d;
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         count_q <= count_q + (AW+1)'(push) - (AW+1)'(pop);
         if (word_stb_i && full) begin
            overflow_o <= 1'b1;
         end
      end
   end

   // Header from the tag of the first word of the packet
   always_comb begin
      hdr_data = '0;
      hdr_data[`CAM_HDR_DEST_MSB:`CAM_HDR_DEST_LSB]   = 5'(`CAM_DEST_ID);
      hdr_data[`CAM_HDR_SRC_MSB:`CAM_HDR_SRC_LSB]     = 5'(`CAM_TILE_ID);
      hdr_data[`CAM_HDR_ZERO_MSB:`CAM_HDR_ZERO_LSB]   = '0;
      hdr_data[`CAM_HDR_FRAME_MSB:`CAM_HDR_FRAME_LSB] = mem_frame[rd_ptr_q];
      hdr_data[`CAM_HDR_LINE_MSB:`CAM_HDR_LINE_LSB]   = mem_line[rd_ptr_q];
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         cam_pkg::PKT_IDLE: begin
            if (!empty) begin
               state_d = cam_pkg::PKT_HEADER;  // Packet start, head entry is its first word
            end
         end
         cam_pkg::PKT_HEADER: begin
            if (noc_out_ready_i) begin
               state_d = cam_pkg::PKT_BODY;
            end
         end
         cam_pkg::PKT_BODY: begin
            if (pop && mem_last[rd_ptr_q]) begin
               state_d = cam_pkg::PKT_IDLE;
            end
         end
         default: state_d = cam_pkg::PKT_IDLE;
      endcase
   end

   // Outputs held by the FIFO head until the transfer
   always_comb begin
      noc_out_valid_o = 1'b0;
      noc_out_flit_o  = {cam_pkg::FLIT_PAYLOAD, mem_word[rd_ptr_q]};
      if (state_q == cam_pkg::PKT_HEADER) begin
         noc_out_valid_o = 1'b1;
         noc_out_flit_o  = {cam_pkg::FLIT_HEADER, hdr_data};
      end else if (state_q == cam_pkg::PKT_BODY) begin
         noc_out_valid_o = ~empty;  // Waits for slow camera data
         if (mem_last[rd_ptr_q]) begin
            noc_out_flit_o = {cam_pkg::FLIT_LAST, mem_word[rd_ptr_q]};
         end
      end
   end

endmodule

/* verilog/cam_noc_system.sv */
// Camera tile NoC link top, camera port in and one lisnoc packet per image line out
module cam_noc_system (
   input  logic               clk,
   input  logic               arst_n_i,
   input  logic               pclk_i,
   input  logic               href_i,
   input  logic               vsync_i,
   input  cam_pkg::cam_byte_t d_i,
   input  logic               noc_out_ready_i,
   output cam_pkg::noc_flit_t noc_out_flit_o,
   output logic               noc_out_valid_o,
   output logic               overflow_o
);

   // Capture to packer
   logic                byte_stb;
   cam_pkg::cam_byte_t  byte_val;
   logic                line_end_stb;
   logic                frame_start_stb;

   // Packer to packetizer, no back-pressure
   logic                word_stb;
   cam_pkg::cam_word_t  word;
   logic                word_last;
   cam_pkg::cam_line_t  word_line;
   cam_pkg::cam_frame_t word_frame;

   cam_capture u_capture (
      .clk               (clk),
      .arst_n_i          (arst_n_i),
      .pclk_i            (pclk_i),
      .href_i            (href_i),
      .vsync_i           (vsync_i),
      .d_i               (d_i),
      .byte_stb_o        (byte_stb),
      .byte_o            (byte_val),
      .line_end_stb_o    (line_end_stb),
      .frame_start_stb_o (frame_start_stb)
   );

   pixel_packer u_packer (
      .clk               (clk),
      .arst_n_i          (arst_n_i),
      .byte_stb_i        (byte_stb),
      .byte_i            (byte_val),
      .line_end_stb_i    (line_end_stb),
      .frame_start_stb_i (frame_start_stb),
      .word_stb_o        (word_stb),
      .word_o            (word),
      .last_o            (word_last),
      .line_o            (word_line),
      .frame_o           (word_frame)
   );

   noc_packetizer u_packetizer (
      .clk             (clk),
      .arst_n_i        (arst_n_i),
      .word_stb_i      (word_stb),
      .word_i          (word),
      .last_i          (word_last),
      .line_i          (word_line),
      .frame_i         (word_frame),
      .noc_out_ready_i (noc_out_ready_i),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .overflow_o      (overflow_o)
   );

endmodule

/* test/cam_noc_asserts.sv */
// Link handshake and strobe assertions, bound into every noc_packetizer instance
module cam_noc_asserts (
   input logic               clk,
   input logic               arst_n_i,
   input logic               word_stb_i,
   input logic               valid_i,
   input logic               ready_i,
   input cam_pkg::noc_flit_t flit_i
);

   logic in_pkt_q;  // Header transferred, last not yet

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         in_pkt_q <= 1'b0;
      end else if (valid_i && ready_i) begin
         if (flit_i[33:32] == cam_pkg::FLIT_HEADER) begin
            in_pkt_q <= 1'b1;
         end else if (flit_i[33:32] == cam_pkg::FLIT_LAST) begin
            in_pkt_q <= 1'b0;
         end
      end
   end

   stall_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
      valid_i && !ready_i |=> valid_i && $stable(flit_i))
      else $error("Flit changed or valid dropped while stalled");

   header_order: assert property (@(posedge clk) disable iff (!arst_n_i)
      valid_i && ready_i && (flit_i[33:32] == cam_pkg::FLIT_HEADER) |-> !in_pkt_q)
      else $error("Second header before the last flit of a packet");

   strobe_known: assert property (@(posedge clk) disable iff (!arst_n_i)
      !$isunknown(word_stb_i) && !$isunknown(valid_i))
      else $error("Unknown strobe or valid after reset");

endmodule

bind noc_packetizer cam_noc_asserts u_asserts (
   .clk        (clk),
   .arst_n_i   (arst_n_i),
   .word_stb_i (word_stb_i),
   .valid_i    (noc_out_valid_o),
   .ready_i    (noc_out_ready_i),
   .flit_i     (noc_out_flit_o)
);

/* test/tb_cam_noc_system.sv */
// Testbench for the camera NoC link, random camera lines checked flit by flit against a packet model
`include "cam_params.svh"

module tb_cam_noc_system;

   logic               clk;
   logic               arst_n_i;
   logic               pclk_i;
   logic               href_i;
   logic               vsync_i;
   cam_pkg::cam_byte_t d_i;
   logic               noc_out_ready_i;
   cam_pkg::noc_flit_t noc_out_flit_o;
   logic               noc_out_valid_o;
   logic               overflow_o;

   logic [31:0]         lcg_state = 32'h6f21;
   cam_pkg::noc_flit_t  exp_q[$];       // Flits still owed by the DUT, oldest first
   cam_pkg::noc_flit_t  exp_flit;
   cam_pkg::cam_frame_t frame_num;      // Model of the frame tag
   cam_pkg::cam_line_t  line_num;       // Model of the line tag
   logic                ready_random;   // Random ready gaps
   logic                ready_level;    // Fixed ready when not random
   logic                check_on;       // Monitor compares flits
   int                  flits_seen;

   cam_noc_system dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function int unsigned rand_range(input int unsigned lo, input int unsigned hi);
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lo + (lcg_state[31:8] % (hi - lo + 1));  // Upper bits, low ones are weak
   endfunction

   task wait_clk(input int n);
      repeat (n) @(posedge clk);
      #2;
   endtask

   task stop_run();
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task check_flit(input string name, input cam_pkg::noc_flit_t exp,
                   input cam_pkg::noc_flit_t act);
      if (act !== exp) begin
         $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
         stop_run();
      end
   endtask

   task check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
         stop_run();
      end
   endtask

   // Frame sync pulse, tags restart
   task start_frame();
      vsync_i = 1'b1;
      wait_clk(rand_range(3, 5));
      vsync_i = 1'b0;
      wait_clk(rand_range(3, 5));
      frame_num = frame_num + 1'b1;
      line_num  = '0;
   endtask

   // One href window of len bytes, model queues header and packed words when asked
   task send_line(input int len, input logic model);
      cam_pkg::cam_word_t w;
      cam_pkg::cam_byte_t b;
      cam_pkg::flit_type_t ftype;
      int i;
      w = '0;
      if (model) begin
         exp_q.push_back({cam_pkg::FLIT_HEADER, 5'(`CAM_DEST_ID), 5'(`CAM_TILE_ID), 4'h0,
                          frame_num, line_num});
      end
      href_i = 1'b1;
      wait_clk(rand_range(3, 5));
      for (i = 0; i < len; i++) begin
         b = 8'(rand_range(0, 255));
         w[(i % 4) * 8 +: 8] = b;        // Little-endian lanes
         pclk_i = 1'b0;
         d_i    = b;                     // Stable across the rising edge
         wait_clk(rand_range(3, 5));
         pclk_i = 1'b1;
         wait_clk(rand_range(3, 5));
         if ((i % 4 == 3) || (i == len - 1)) begin
            ftype = (i == len - 1) ? cam_pkg::FLIT_LAST : cam_pkg::FLIT_PAYLOAD;
            if (model) begin
               exp_q.push_back({ftype, w});
            end
            w = '0;                      // Upper lanes of a short word stay zero
         end
      end
      pclk_i = 1'b0;
      href_i = 1'b0;
      wait_clk(rand_range(3, 5));
      line_num = line_num + 1'b1;
   endtask

   task wait_drain(input int max_cycles);
      int n;
      n = 0;
      while (exp_q.size() != 0) begin
         if (n == max_cycles) begin
            $display("Timeout, %0d expected flits never arrived", exp_q.size());
            stop_run();
         end else begin
            wait_clk(1);
            n++;
         end
      end
   endtask

   // Ready driver, next level picked at the edge and driven with the other inputs
   initial begin
      logic ready_next;
      noc_out_ready_i = 1'b0;
      forever begin
         @(posedge clk);
         if (ready_random) begin
            ready_next = (rand_range(0, 3) != 0);  // About one gap in four
         end else begin
            ready_next = ready_level;
         end
         #2;
         noc_out_ready_i = ready_next;
      end
   end

   // Monitor at the falling edge, link signals settled
   always @(negedge clk) begin
      if (arst_n_i && check_on) begin
         check_flag("overflow_o", 1'b0, overflow_o);
         if (noc_out_valid_o && noc_out_ready_i) begin
            if (exp_q.size() == 0) begin
               $display("A flit was transferred while none was expected");
               stop_run();
            end else begin
               exp_flit = exp_q.pop_front();
               check_flit("noc_out_flit_o", exp_flit, noc_out_flit_o);
               flits_seen++;
            end
         end
      end
   end

   initial begin
      int f;
      int l;
      int nlines;
      arst_n_i     = 1'b0;
      pclk_i       = 1'b0;
      href_i       = 1'b0;
      vsync_i      = 1'b0;
      d_i          = '0;
      ready_random = 1'b0;
      ready_level  = 1'b0;
      check_on     = 1'b0;
      frame_num    = '0;
      line_num     = '0;
      flits_seen   = 0;
      wait_clk(8);
      arst_n_i = 1'b1;
      wait_clk(4);
      check_flag("noc_out_valid_o", 1'b0, noc_out_valid_o);  // Idle link after reset
      check_flag("overflow_o", 1'b0, overflow_o);
      check_on     = 1'b1;
      ready_random = 1'b1;
      for (f = 0; f < 3; f++) begin
         start_frame();
         nlines = rand_range(2, 4);
         for (l = 0; l < nlines; l++) begin
            send_line(rand_range(1, 13), 1'b1);
            wait_drain(400);
         end
      end
      // Stalled link, line longer than the FIFO
      check_on     = 1'b0;
      ready_random = 1'b0;
      ready_level  = 1'b0;
      wait_clk(2);
      send_line(4 * (`CAM_FIFO_DEPTH + 2), 1'b0);
      check_flag("overflow_o", 1'b1, overflow_o);
      ready_level = 1'b1;
      wait_clk(50);
      check_flag("overflow_o", 1'b1, overflow_o);  // Sticky after the stall ends
      arst_n_i = 1'b0;
      wait_clk(8);
      arst_n_i = 1'b1;
      wait_clk(4);
      check_flag("noc_out_valid_o", 1'b0, noc_out_valid_o);
      check_flag("overflow_o", 1'b0, overflow_o);
      $display("%0d flits checked", flits_seen);
      $display("=== PASS ===");
      $finish;
   end

endmodule

/* all.f */
+incdir+common
common/cam_pkg.sv
camera/cam_capture.sv
camera/pixel_packer.sv
verilog/noc_packetizer.sv
verilog/cam_noc_system.sv
test/cam_noc_asserts.sv
test/tb_cam_noc_system.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module tb_cam_noc_system -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "=== FAIL ===" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
   echo "Simulation ended without a verdict"
   exit 1
fi
